/* hw/rvCorePkg.sv */
package rvCorePkg;

    // Base opcodes of the supported instruction groups
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcOp     = 7'b0110011;

    // One instruction word seen through each RV32I layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instrWord;

    // What the control does with the instruction
    typedef enum logic [3:0] {
        opLui, opAuipc, opJal, opJalr, opBranch,
        opLoad, opStore, opImm, opReg, opIllegal
    } opClassE;

    // ALU functions, named after the RV32I mnemonics
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOpE;

endpackage

/* hw/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf;
    import rvCorePkg::*;

    // Latched word from the instruction register
    instrWord    instr;

    // Decoded fields, valid in the same cycle as instr
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [4:0]  wa;
    logic [31:0] imm;
    opClassE     opClass;
    aluOpE       aluOp;
    logic [2:0]  funct3;
    // Operand b from the immediate instead of rs2
    logic        useImm;

    modport control (output instr,
                     input ra1, ra2, wa, imm, opClass, aluOp, funct3, useImm);

    modport decoder (input instr,
                     output ra1, ra2, wa, imm, opClass, aluOp, funct3, useImm);

endinterface

/* hw/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    decodeIf.decoder dec
);
    import rvCorePkg::*;

    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    aluOpE       arithOp;

    assign opcode = dec.instr.rType.opcode;
    assign f3     = dec.instr.rType.funct3;
    // Bit 30 picks SUB and SRA
    assign alt    = dec.instr.rType.funct7[5];

    assign dec.funct3 = f3;

    // All immediates sign-extend from instruction bit 31
    assign immI = {{20{dec.instr.iType.imm[11]}}, dec.instr.iType.imm};
    assign immS = {{20{dec.instr.sType.immHi[6]}}, dec.instr.sType.immHi,
                   dec.instr.sType.immLo};
    // Branch and jump offsets are halfword multiples
    assign immB = {{19{dec.instr.bType.imm12}}, dec.instr.bType.imm12,
                   dec.instr.bType.imm11, dec.instr.bType.imm10to5,
                   dec.instr.bType.imm4to1, 1'b0};
    assign immU = {dec.instr.uType.imm, 12'h000};
    assign immJ = {{11{dec.instr.jType.imm20}}, dec.instr.jType.imm20,
                   dec.instr.jType.imm19to12, dec.instr.jType.imm11,
                   dec.instr.jType.imm10to1, 1'b0};

    // Shared by OP and OP-IMM
    always_comb
    begin
        case (f3)
            // No SUBI, so alt only counts for the register form
            3'b000:  arithOp = (alt && opcode == opcOp) ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b011:  arithOp = aluSltu;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = alt ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    end

    always_comb
    begin
        // I-type defaults, overridden per group
        dec.ra1     = dec.instr.rType.rs1;
        dec.ra2     = dec.instr.rType.rs2;
        dec.wa      = dec.instr.rType.rd;
        dec.imm     = immI;
        dec.opClass = opIllegal;
        dec.aluOp   = aluAdd;
        dec.useImm  = 1'b1;
        case (opcode)
            opcLui:
            begin
                dec.opClass = opLui;
                dec.ra1     = '0;
                dec.ra2     = '0;
                dec.imm     = immU;
            end
            opcAuipc:
            begin
                dec.opClass = opAuipc;
                dec.ra1     = '0;
                dec.ra2     = '0;
                dec.imm     = immU;
            end
            opcJal:
            begin
                dec.opClass = opJal;
                dec.ra1     = '0;
                dec.ra2     = '0;
                dec.imm     = immJ;
            end
            opcJalr:
            begin
                dec.opClass = opJalr;
                dec.ra2     = '0;
            end
            opcBranch:
            begin
                // Compare rs1 against rs2, no write-back
                dec.opClass = opBranch;
                dec.wa      = '0;
                dec.imm     = immB;
                dec.useImm  = 1'b0;
            end
            opcLoad:
            begin
                // Word access only
                if (f3 == 3'b010)
                    dec.opClass = opLoad;
                dec.ra2 = '0;
            end
            opcStore:
            begin
                if (f3 == 3'b010)
                    dec.opClass = opStore;
                dec.wa  = '0;
                dec.imm = immS;
            end
            opcOpImm:
            begin
                dec.opClass = opImm;
                dec.ra2     = '0;
                dec.aluOp   = arithOp;
            end
            opcOp:
            begin
                dec.opClass = opReg;
                dec.imm     = '0;
                dec.useImm  = 1'b0;
                dec.aluOp   = arithOp;
            end
            default:
            begin
                // Unsupported, core halts in EXEC
                dec.ra1 = '0;
                dec.ra2 = '0;
                dec.wa  = '0;
            end
        endcase
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && wa != 5'd0)
        begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous read ports
    assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  rvCorePkg::aluOpE  op,
    input  logic [2:0]        funct3,
    output logic [31:0]       result,
    output logic              taken
);
    import rvCorePkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << shamt;
            aluSlt:  result = {31'h0, $signed(a) < $signed(b)};
            aluSltu: result = {31'h0, a < b};
            aluXor:  result = a ^ b;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $unsigned($signed(a) >>> shamt);
            aluOr:   result = a | b;
            default: result = a & b;
        endcase
    end

    // Branch condition, funct3 of the B-type word
    always_comb
    begin
        case (funct3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            3'b111:  taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

endmodule

/* hw/coreControl.sv */
`timescale 1ns/1ps

module coreControl #(
    parameter logic [31:0] resetAddr = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    decodeIf.control    dec,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    input  logic [31:0] aluResult,
    input  logic        taken,
    output logic [31:0] aluA,
    output logic [31:0] aluB,
    output logic [31:0] wd,
    output logic        rfWe,
    output logic        wbCyc,
    output logic        wbStb,
    output logic        wbWe,
    output logic [31:0] wbAdr,
    output logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic        wbAck,
    output logic        halted
);
    import rvCorePkg::*;

    typedef enum logic [2:0] {
        stFetch, stDecode, stExec, stMem, stWb, stHalt
    } stateE;

    stateE       state;
    logic [31:0] pc;
    instrWord    ir;
    // Results held from EXEC and MEM until WB
    logic [31:0] resultQ;
    logic [31:0] loadQ;
    logic [31:0] pcNext;
    logic [31:0] pcPlus4;
    logic [31:0] pcPlusImm;
    logic        memAccess;

    assign dec.instr = ir;

    assign pcPlus4   = pc + 32'd4;
    // Branch and JAL target
    assign pcPlusImm = pc + dec.imm;
    assign memAccess = (dec.opClass == opLoad) || (dec.opClass == opStore);

    // Operand select, PC only for AUIPC
    assign aluA = (dec.opClass == opAuipc) ? pc : rd1;
    assign aluB = dec.useImm ? dec.imm : rd2;

    // Stores and branches carry wa = 0, so WB alone enables the write
    assign rfWe   = (state == stWb);
    assign halted = (state == stHalt);

    always_comb
    begin
        case (dec.opClass)
            opLoad:        wd = loadQ;
            opJal, opJalr: wd = pcPlus4;
            opLui:         wd = dec.imm;
            default:       wd = resultQ;
        endcase
    end

    // State, PC and bus handshake
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= stFetch;
            pc    <= resetAddr;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
        end
        else
        begin
            case (state)
                stFetch:
                begin
                    // Cycle is already open except right after reset
                    if (!wbCyc)
                    begin
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                    end
                    else if (wbAck)
                    begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        state <= stDecode;
                    end
                end
                stDecode:
                    state <= stExec;
                stExec:
                begin
                    if (dec.opClass == opIllegal)
                        state <= stHalt;
                    else if (memAccess)
                    begin
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbWe  <= (dec.opClass == opStore);
                        state <= stMem;
                    end
                    else
                        state <= stWb;
                end
                stMem:
                begin
                    if (wbAck)
                    begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        wbWe  <= 1'b0;
                        state <= stWb;
                    end
                end
                stWb:
                begin
                    // Next fetch starts together with the PC update
                    pc    <= pcNext;
                    wbCyc <= 1'b1;
                    wbStb <= 1'b1;
                    state <= stFetch;
                end
                default:
                    state <= stHalt;
            endcase
        end
    end

    // Instruction, results and bus payload
    always_ff @(posedge clk)
    begin
        case (state)
            stFetch:
            begin
                if (!wbCyc)
                    wbAdr <= pc;
                else if (wbAck)
                    ir <= wbDatR;
            end
            stExec:
            begin
                resultQ <= aluResult;
                // Load and store address from rs1 + imm
                wbAdr   <= aluResult;
                wbDatW  <= rd2;
                case (dec.opClass)
                    opJal:    pcNext <= pcPlusImm;
                    opJalr:   pcNext <= {aluResult[31:1], 1'b0};
                    opBranch: pcNext <= taken ? pcPlusImm : pcPlus4;
                    default:  pcNext <= pcPlus4;
                endcase
            end
            stMem:
            begin
                if (wbAck)
                    loadQ <= wbDatR;
            end
            stWb:
                wbAdr <= pcNext;
            default:
            begin
            end
        endcase
    end

endmodule

/* hw/rvCore.sv */
`timescale 1ns/1ps

module rvCore #(
    parameter logic [31:0] resetAddr = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    output logic        wbCyc,
    output logic        wbStb,
    output logic        wbWe,
    output logic [31:0] wbAdr,
    output logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic        wbAck,
    output logic        halted
);

    // Register file read data
    logic [31:0] rd1;
    logic [31:0] rd2;
    // ALU operands and results
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        taken;
    // Write-back port
    logic [31:0] wd;
    logic        rfWe;

    decodeIf decBus ();

    instrDecode uDecode (
        .dec (decBus.decoder)
    );

    regFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (decBus.ra1),
        .ra2  (decBus.ra2),
        .wa   (decBus.wa),
        .wd   (wd),
        .we   (rfWe),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    alu uAlu (
        .a      (aluA),
        .b      (aluB),
        .op     (decBus.aluOp),
        .funct3 (decBus.funct3),
        .result (aluResult),
        .taken  (taken)
    );

    coreControl #(
        .resetAddr (resetAddr)
    ) uControl (
        .clk       (clk),
        .rstN      (rstN),
        .dec       (decBus.control),
        .rd1       (rd1),
        .rd2       (rd2),
        .aluResult (aluResult),
        .taken     (taken),
        .aluA      (aluA),
        .aluB      (aluB),
        .wd        (wd),
        .rfWe      (rfWe),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .halted    (halted)
    );

endmodule

/* verification/rvCore_chk.sv */
`timescale 1ns/1ps

module rvCoreChk (
    input logic        clk,
    input logic        rstN,
    input logic        wbCyc,
    input logic        wbStb,
    input logic        wbWe,
    input logic [31:0] wbAdr,
    input logic [31:0] wbDatW,
    input logic        wbAck,
    input logic        halted
);

    // Strobe only inside a cycle
    stbInCyc: assert property (@(posedge clk) disable iff (!rstN)
        wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    // Waiting strobe keeps its payload
    stbHold: assert property (@(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbDatW) && $stable(wbWe)))
        else $error("Bus request changed before ack");

    // Halt is permanent
    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped without reset");

    // No bus traffic once halted
    haltQuiet: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !wbCyc)
        else $error("Bus cycle while halted");

endmodule

bind rvCore rvCoreChk uChk (
    .clk    (clk),
    .rstN   (rstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbAck  (wbAck),
    .halted (halted)
);

/* verification/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb;
    import rvCorePkg::*;

    localparam int          cycleLimit = 2000;
    localparam logic [31:0] resultBase = 32'h0000_0300;
    localparam logic [31:0] dataBase   = 32'h0000_03E0;

    logic        clk;
    logic        rstN;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;
    logic        halted;

    // Program, results and data share one word-addressed memory
    logic [31:0] mem [0:255];
    logic [31:0] expAdr [0:63];
    logic [31:0] expDat [0:63];
    string       expName [0:63];
    int          nExp;
    int          seen;
    int          pcW;
    int          resOff;
    int          waitCnt;
    int          cycles;
    int          haltCycles;
    logic [31:0] jalrAt;
    logic [31:0] prevRead;

    rvCore #(
        .resetAddr (32'h0000_0000)
    ) u_rvCore (
        .clk    (clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .halted (halted)
    );

    always #10 clk = ~clk;

    // RV32I instruction layouts
    function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcOp};
    endfunction

    function automatic logic [31:0] iFormat(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sFormat(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};
    endfunction

    function automatic logic [31:0] bFormat(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic logic [31:0] uFormat(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jFormat(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Branch conditions as the ISA defines them
    function automatic logic branchRule(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] pcNow();
        return 32'(pcW) << 2;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[pcW] = word;
        pcW++;
    endtask

    // SW rs to rb + off, recording the expected bus write
    task automatic storeAt(input string name, input logic [4:0] rs, input logic [4:0] rb,
                           input logic [31:0] baseVal, input logic [11:0] off,
                           input logic [31:0] value);
        emit(sFormat(off, rs, rb));
        expName[nExp] = name;
        expAdr[nExp]  = baseVal + sext12(off);
        expDat[nExp]  = value;
        nExp++;
    endtask

    task automatic storeResult(input string name, input logic [4:0] rs,
                               input logic [31:0] value);
        storeAt(name, rs, 5'd2, resultBase, 12'(resOff), value);
        resOff += 4;
    endtask

    // LUI plus ADDI, upper part rounded for the signed low part
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(uFormat(hi[31:12], rd, opcLui));
        emit(iFormat(value[11:0], rd, 3'b000, rd, opcOpImm));
    endtask

    // Marker 0x11 survives when taken, 0x22 overwrites it otherwise
    task automatic branchCase(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [31:0] a,
                              input logic [31:0] b);
        emit(iFormat(12'h011, 5'd0, 3'b000, 5'd13, opcOpImm));
        emit(bFormat(13'd8, rs2, rs1, f3));
        emit(iFormat(12'h022, 5'd0, 3'b000, 5'd13, opcOpImm));
        storeResult(name, 5'd13, branchRule(f3, a, b) ? 32'h11 : 32'h22);
    endtask

    initial
    begin
        logic [31:0] c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] dataWord;
        logic [31:0] neg5;
        logic [31:0] pa;
        // Seeded draw gives the first wait count
        waitCnt  = int'($urandom(32'h5bd0c755) % 32'd4);
        clk      = 1'b0;
        rstN     = 1'b0;
        wbDatR   = '0;
        wbAck    = 1'b0;
        nExp     = 0;
        seen     = 0;
        pcW      = 0;
        resOff   = 0;
        cycles   = 0;
        haltCycles = 0;
        prevRead = 32'hFFFF_FFFF;
        for (int i = 0; i < 256; i++)
            mem[i] = {16'hA5C3, 8'(i), 8'(i) ^ 8'h5A};
        dataWord = $urandom;
        mem[(dataBase - 32'd8) >> 2] = dataWord;

        // Pointers to the result and data areas
        loadConst(5'd2, resultBase);
        loadConst(5'd3, dataBase);

        // Immediate arithmetic on a negative constant
        c = 32'h8000_0F35;
        loadConst(5'd5, c);
        emit(iFormat(12'hFF9, 5'd5, 3'b000, 5'd6, opcOpImm));
        storeResult("addi", 5'd6, c + sext12(12'hFF9));
        emit(iFormat(12'hFFF, 5'd5, 3'b010, 5'd6, opcOpImm));
        storeResult("slti", 5'd6, {31'b0, $signed(c) < $signed(sext12(12'hFFF))});
        emit(iFormat(12'hFFF, 5'd5, 3'b011, 5'd6, opcOpImm));
        storeResult("sltiu", 5'd6, {31'b0, c < sext12(12'hFFF)});
        emit(iFormat(12'hAAB, 5'd5, 3'b100, 5'd6, opcOpImm));
        storeResult("xori", 5'd6, c ^ sext12(12'hAAB));
        emit(iFormat(12'h0F0, 5'd5, 3'b110, 5'd6, opcOpImm));
        storeResult("ori", 5'd6, c | sext12(12'h0F0));
        emit(iFormat(12'hFF0, 5'd5, 3'b111, 5'd6, opcOpImm));
        storeResult("andi", 5'd6, c & sext12(12'hFF0));
        emit(iFormat(12'h005, 5'd5, 3'b001, 5'd6, opcOpImm));
        storeResult("slli", 5'd6, c << 5);
        emit(iFormat(12'h007, 5'd5, 3'b101, 5'd6, opcOpImm));
        storeResult("srli", 5'd6, c >> 7);
        emit(iFormat(12'h407, 5'd5, 3'b101, 5'd6, opcOpImm));
        storeResult("srai", 5'd6, 32'($signed(c) >>> 7));

        // Register ops on random operands
        a = $urandom;
        b = $urandom;
        loadConst(5'd7, a);
        loadConst(5'd8, b);
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b000, 5'd9));
        storeResult("add", 5'd9, a + b);
        emit(rFormat(7'h20, 5'd8, 5'd7, 3'b000, 5'd9));
        storeResult("sub", 5'd9, a - b);
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b001, 5'd9));
        storeResult("sll", 5'd9, a << b[4:0]);
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b010, 5'd9));
        storeResult("slt", 5'd9, {31'b0, $signed(a) < $signed(b)});
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b011, 5'd9));
        storeResult("sltu", 5'd9, {31'b0, a < b});
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b100, 5'd9));
        storeResult("xor", 5'd9, a ^ b);
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b101, 5'd9));
        storeResult("srl", 5'd9, a >> b[4:0]);
        emit(rFormat(7'h20, 5'd8, 5'd7, 3'b101, 5'd9));
        storeResult("sra", 5'd9, 32'($signed(a) >>> b[4:0]));
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b110, 5'd9));
        storeResult("or", 5'd9, a | b);
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b111, 5'd9));
        storeResult("and", 5'd9, a & b);
        // Writes to x0 are dropped
        emit(iFormat(12'h005, 5'd0, 3'b000, 5'd0, opcOpImm));
        emit(rFormat(7'h00, 5'd8, 5'd7, 3'b000, 5'd0));
        storeResult("x0", 5'd0, 32'h0);

        // Load with negative offset, stored back twice
        emit(iFormat(12'hFF8, 5'd3, 3'b010, 5'd10, opcLoad));
        storeAt("swNegOff", 5'd10, 5'd3, dataBase, 12'hFFC, dataWord);
        storeResult("lwCopy", 5'd10, dataWord);

        // Branch operands, x11 = x14 = -5, x12 = 3
        neg5 = 32'hFFFF_FFFB;
        emit(iFormat(12'hFFB, 5'd0, 3'b000, 5'd11, opcOpImm));
        emit(iFormat(12'h003, 5'd0, 3'b000, 5'd12, opcOpImm));
        emit(iFormat(12'hFFB, 5'd0, 3'b000, 5'd14, opcOpImm));
        branchCase("beqT", 3'b000, 5'd11, 5'd14, neg5, neg5);
        branchCase("beqN", 3'b000, 5'd11, 5'd12, neg5, 32'd3);
        branchCase("bneT", 3'b001, 5'd11, 5'd12, neg5, 32'd3);
        branchCase("bneN", 3'b001, 5'd11, 5'd14, neg5, neg5);
        branchCase("bltT", 3'b100, 5'd11, 5'd12, neg5, 32'd3);
        branchCase("bltN", 3'b100, 5'd12, 5'd11, 32'd3, neg5);
        branchCase("bgeT", 3'b101, 5'd12, 5'd11, 32'd3, neg5);
        branchCase("bgeN", 3'b101, 5'd11, 5'd12, neg5, 32'd3);
        branchCase("bltuT", 3'b110, 5'd12, 5'd11, 32'd3, neg5);
        branchCase("bltuN", 3'b110, 5'd11, 5'd12, neg5, 32'd3);
        branchCase("bgeuT", 3'b111, 5'd11, 5'd12, neg5, 32'd3);
        branchCase("bgeuN", 3'b111, 5'd12, 5'd11, 32'd3, neg5);

        // Counted loop, five passes adding 3
        emit(iFormat(12'h000, 5'd0, 3'b000, 5'd15, opcOpImm));
        emit(iFormat(12'h005, 5'd0, 3'b000, 5'd16, opcOpImm));
        emit(iFormat(12'h003, 5'd15, 3'b000, 5'd15, opcOpImm));
        emit(iFormat(12'hFFF, 5'd16, 3'b000, 5'd16, opcOpImm));
        emit(bFormat(13'h1FF8, 5'd0, 5'd16, 3'b001));
        storeResult("loop", 5'd15, 32'd15);

        // AUIPC, then JAL over one instruction
        pa = pcNow();
        emit(uFormat(20'h12345, 5'd21, opcAuipc));
        storeResult("auipc", 5'd21, pa + 32'h1234_5000);
        pa = pcNow();
        emit(jFormat(21'd8, 5'd17));
        emit(iFormat(12'h7FF, 5'd0, 3'b000, 5'd19, opcOpImm));
        storeResult("jalLink", 5'd17, pa + 32'd4);
        storeResult("jalSkip", 5'd19, 32'h0);

        // JALR with odd offset 13 lands on pa + 12
        pa = pcNow();
        jalrAt = pa + 32'd4;
        emit(uFormat(20'h00000, 5'd20, opcAuipc));
        emit(iFormat(12'd13, 5'd20, 3'b000, 5'd22, opcJalr));
        emit(iFormat(12'h055, 5'd0, 3'b000, 5'd19, opcOpImm));
        storeResult("jalrLink", 5'd22, pa + 32'd8);
        storeResult("jalrSkip", 5'd19, 32'h0);

        // Custom-0 opcode halts the core
        emit(32'h0000_000B);

        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
    end

    // Wishbone slave, 0 to 3 wait cycles per strobe
    always @(posedge clk)
    begin
        #1;
        if (wbAck)
        begin
            wbAck   = 1'b0;
            waitCnt = int'($urandom % 32'd4);
        end
        else if (wbCyc && wbStb)
        begin
            if (waitCnt > 0)
                waitCnt--;
            else
            begin
                assert (wbAdr[1:0] == 2'b00)
                else
                begin
                    $display("Bus address %h is not word aligned", wbAdr);
                    $display("Test failures found");
                    $fatal(1);
                end
                if (wbWe)
                begin
                    assert (seen < nExp)
                    else
                    begin
                        $display("Store to %h beyond the expected stores", wbAdr);
                        $display("Test failures found");
                        $fatal(1);
                    end
                    assert (wbAdr == expAdr[seen] && wbDatW == expDat[seen])
                    else
                    begin
                        $display("ERR %s expected adr %h data %h actual adr %h data %h",
                                 expName[seen], expAdr[seen], expDat[seen], wbAdr, wbDatW);
                        $display("Test failures found");
                        $fatal(1);
                    end
                    seen++;
                    mem[wbAdr[9:2]] = wbDatW;
                end
                else
                begin
                    // Fetch after the JALR goes to the even target
                    if (prevRead == jalrAt)
                    begin
                        assert (wbAdr == jalrAt + 32'd8)
                        else
                        begin
                            $display("ERR jalrTarget expected %h actual %h",
                                     jalrAt + 32'd8, wbAdr);
                            $display("Test failures found");
                            $fatal(1);
                        end
                    end
                    prevRead = wbAdr;
                    wbDatR   = mem[wbAdr[9:2]];
                end
                wbAck = 1'b1;
            end
        end
    end

    // End of run on halt, with a few idle cycles for the checker
    always @(posedge clk)
    begin
        #2;
        cycles++;
        if (halted)
            haltCycles++;
        if (haltCycles == 10)
        begin
            assert (seen == nExp)
            begin
                $display("All tests passed!");
                $finish;
            end
            else
            begin
                $display("Core halted after %0d of %0d expected stores", seen, nExp);
                $display("Test failures found");
                $fatal(1);
            end
        end
        else if (cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles without halting", cycles);
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

/* rvCore.f */
hw/rvCorePkg.sv
hw/decodeIf.sv
hw/instrDecode.sv
hw/regFile.sv
hw/alu.sv
hw/coreControl.sv
hw/rvCore.sv
verification/rvCore_chk.sv
verification/rvCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rvCoreTb \
    -f rvCore.f \
    -o rvCoreSim

./obj_dir/rvCoreSim
